//--- sim.f
source/fpu_pkg.sv
source/fp_decode.sv
source/fp_regfile.sv
source/fp_operand_fwd.sv
source/fp_csr.sv
source/fp_issue_reg.sv
source/fpu_front.sv
tb/fpu_front_tb.sv

//--- tb/fpu_front_tb.sv
`timescale 1ns/1ps

module fpu_front_tb;
  import fpu_pkg::*;

  // 2000 instructions plus 200 CSR accesses at up to 3 cycles each, with margin.
  localparam int MAX_CYCLES = 4000;
  localparam int ROUNDS     = 20;

  logic      clock = 1'b0;
  logic      reset;
  instr_t    instr_i;
  logic      instr_valid_i;
  logic      wb_wren_i, ex_wren_i, mem_wren_i;
  reg_addr_t wb_waddr_i, ex_waddr_i, mem_waddr_i;
  fp_data_t  wb_wdata_i, ex_wdata_i, mem_wdata_i;
  logic      exc_valid_i;
  fflags_t   exc_fflags_i;
  logic      wb_cyc_i, wb_stb_i, wb_we_i;
  csr_addr_t wb_adr_i;
  csr_data_t wb_dat_i, wb_dat_o;
  logic      wb_ack_o;
  logic      issue_valid_o, issue_illegal_o;
  fp_op_e    issue_op_o;
  logic [31:0] issue_imm_o;
  fmt_t      issue_fmt_o;
  rm_t       issue_rm_o;
  reg_addr_t issue_rd_o;
  logic      issue_int_rden_o, issue_int_wren_o, issue_fp_wren_o;
  fp_data_t  issue_op1_o, issue_op2_o, issue_op3_o;

  integer    seed;
  int        checks = 0;
  int        errors = 0;
  int        cycle_count = 0;
  fp_data_t  regs_model [NUM_FP_REGS];
  fflags_t   fflags_model = '0;
  rm_t       frm_model = '0;

  fpu_front dut_i (.*);

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Run did not finish within %0d cycles", MAX_CYCLES);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Random sources and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  function automatic reg_addr_t small_addr();
    logic [31:0] r;
    r = next_random();
    small_addr = {2'b00, r[2:0]};   // Narrow range so forwarding hits.
  endfunction

  function automatic logic [4:0] funct5_pick(input int idx);
    case (idx)
      0:       funct5_pick = FUNCT_FADD;
      1:       funct5_pick = FUNCT_FSUB;
      2:       funct5_pick = FUNCT_FMUL;
      3:       funct5_pick = FUNCT_FDIV;
      4:       funct5_pick = FUNCT_FSQRT;
      5:       funct5_pick = FUNCT_FSGNJ;
      6:       funct5_pick = FUNCT_FMINMAX;
      7:       funct5_pick = FUNCT_FCMP;
      8:       funct5_pick = FUNCT_FMV_F2I;
      9:       funct5_pick = FUNCT_FMV_I2F;
      10:      funct5_pick = FUNCT_FCVT_F2F;
      11:      funct5_pick = FUNCT_FCVT_F2I;
      default: funct5_pick = FUNCT_FCVT_I2F;
    endcase
  endfunction

  function automatic instr_t random_instr();
    instr_t      w;
    logic [31:0] r;
    w = next_random();
    r = next_random();
    w[19:15] = {2'b00, r[2:0]};
    w[24:20] = {2'b00, r[5:3]};
    case (r[8:6])
      3'd0: begin
        w[6:0] = OPCODE_FLOAD;
        if (!r[9]) w[14:12] = {2'b01, r[10]};   // Mostly word or double.
      end
      3'd1: begin
        w[6:0] = OPCODE_FSTORE;
        if (!r[9]) w[14:12] = {2'b01, r[10]};
      end
      3'd2, 3'd3, 3'd4: begin
        w[6:0]   = OPCODE_FP;
        w[31:27] = funct5_pick(int'(r[31:16] % 13));
      end
      3'd5: begin
        case (r[13:12])
          2'd0:    w[6:0] = OPCODE_FMADD;
          2'd1:    w[6:0] = OPCODE_FMSUB;
          2'd2:    w[6:0] = OPCODE_FNMSUB;
          default: w[6:0] = OPCODE_FNMADD;
        endcase
        w[31:27] = {2'b00, r[16:14]};   // Small rs3.
      end
      default: ;
    endcase
    random_instr = w;
  endfunction

  function automatic void decode_expected(input instr_t w, output fp_op_e op,
                                          output logic illegal, output logic [31:0] imm,
                                          output logic [2:0] rden, output logic int_rden,
                                          output logic int_wren, output logic fp_wren);
    fp_op_e base;
    logic   rounds;
    logic [2:0] f3;
    f3   = w[14:12];
    base = OP_NONE;
    if (w[6:0] == OPCODE_FLOAD) base = (f3 == 3'd2) ? OP_FLW : (f3 == 3'd3) ? OP_FLD : OP_NONE;
    if (w[6:0] == OPCODE_FSTORE) base = (f3 == 3'd2) ? OP_FSW : (f3 == 3'd3) ? OP_FSD : OP_NONE;
    if (w[6:0] == OPCODE_FMADD)  base = OP_FMADD;
    if (w[6:0] == OPCODE_FMSUB)  base = OP_FMSUB;
    if (w[6:0] == OPCODE_FNMSUB) base = OP_FNMSUB;
    if (w[6:0] == OPCODE_FNMADD) base = OP_FNMADD;
    if (w[6:0] == OPCODE_FP) begin
      case (w[31:27])
        5'b00000: base = OP_FADD;
        5'b00001: base = OP_FSUB;
        5'b00010: base = OP_FMUL;
        5'b00011: base = OP_FDIV;
        5'b01011: base = OP_FSQRT;
        5'b00100: base = OP_FSGNJ;
        5'b00101: base = OP_FMINMAX;
        5'b10100: base = OP_FCMP;
        5'b11100: base = (f3 == 3'd0) ? OP_FMV_F2I : (f3 == 3'd1) ? OP_FCLASS : OP_NONE;
        5'b11110: base = OP_FMV_I2F;
        5'b01000: base = OP_FCVT_F2F;
        5'b11000: base = OP_FCVT_F2I;
        5'b11010: base = OP_FCVT_I2F;
        default:  base = OP_NONE;
      endcase
    end
    imm      = '0;
    rden     = 3'b000;
    int_rden = 1'b0;
    int_wren = 1'b0;
    fp_wren  = 1'b0;
    case (base)
      OP_FLW, OP_FLD: begin
        imm = {{20{w[31]}}, w[31:20]};
        int_rden = 1'b1;
        fp_wren  = 1'b1;
      end
      OP_FSW, OP_FSD: begin
        imm = {{20{w[31]}}, w[31:25], w[11:7]};
        int_rden = 1'b1;
        rden     = 3'b010;
      end
      OP_FADD, OP_FSUB, OP_FMUL, OP_FDIV, OP_FSGNJ, OP_FMINMAX: {rden, fp_wren} = 4'b0111;
      OP_FSQRT, OP_FCVT_F2F:              {rden, fp_wren} = 4'b0011;
      OP_FCMP:                            {rden, int_wren} = 4'b0111;
      OP_FMV_F2I, OP_FCLASS, OP_FCVT_F2I: {rden, int_wren} = 4'b0011;
      OP_FMV_I2F, OP_FCVT_I2F:            {int_rden, fp_wren} = 2'b11;
      OP_FMADD, OP_FMSUB, OP_FNMSUB, OP_FNMADD: {rden, fp_wren} = 4'b1111;
      default: ;
    endcase
    rounds  = base inside {OP_FADD, OP_FSUB, OP_FMUL, OP_FDIV, OP_FSQRT, OP_FCVT_F2F,
                           OP_FCVT_F2I, OP_FCVT_I2F, OP_FMADD, OP_FMSUB, OP_FNMSUB, OP_FNMADD};
    illegal = (base == OP_NONE) || (rounds && (f3 == 3'd5 || f3 == 3'd6));
    op      = illegal ? OP_NONE : base;
  endfunction

  function automatic fp_data_t forward_expected(input logic en, input reg_addr_t a);
    if (!en) forward_expected = '0;
    else if (ex_wren_i && ex_waddr_i == a) forward_expected = ex_wdata_i;
    else if (mem_wren_i && mem_waddr_i == a) forward_expected = mem_wdata_i;
    else forward_expected = regs_model[a];
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("MISMATCH %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
  endtask

  task automatic issue_random_instr();
    instr_t      w;
    logic [31:0] r;
    fp_op_e      e_op;
    logic        e_valid, e_ill, e_ir, e_iw, e_fw;
    logic [31:0] e_imm;
    logic [2:0]  e_rden;
    rm_t         e_rm;
    fp_data_t    e_opnd [3];
    w = random_instr();
    r = next_random();
    e_valid = (r[3:0] != 4'h0);
    instr_i = w;
    instr_valid_i = e_valid;
    wb_wren_i  = r[4];
    wb_waddr_i = small_addr();
    wb_wdata_i = {next_random(), next_random()};
    ex_wren_i  = r[5];
    ex_waddr_i = small_addr();
    ex_wdata_i = {next_random(), next_random()};
    mem_wren_i  = r[6];
    mem_waddr_i = small_addr();
    mem_wdata_i = {next_random(), next_random()};
    exc_valid_i  = (r[11:8] == 4'h0);
    exc_fflags_i = r[16:12];
    decode_expected(w, e_op, e_ill, e_imm, e_rden, e_ir, e_iw, e_fw);
    e_rm = (w[14:12] == RM_DYN) ? frm_model : w[14:12];
    e_opnd[0] = forward_expected(e_rden[0], w[19:15]);
    e_opnd[1] = forward_expected(e_rden[1], w[24:20]);
    e_opnd[2] = forward_expected(e_rden[2], w[31:27]);
    if (wb_wren_i) regs_model[wb_waddr_i] = wb_wdata_i;   // Lands after this cycle's reads.
    if (exc_valid_i) fflags_model = exc_fflags_i;
    @(negedge clock);
    check_value("issue_valid_o", issue_valid_o, e_valid);
    if (e_valid) begin
      check_value("issue_op_o", issue_op_o, e_op);
      check_value("issue_illegal_o", issue_illegal_o, e_ill);
      check_value("issue_imm_o", issue_imm_o, e_imm);
      check_value("issue_fmt_o", issue_fmt_o, w[26:25]);
      check_value("issue_rm_o", issue_rm_o, e_rm);
      check_value("issue_rd_o", issue_rd_o, w[11:7]);
      check_value("issue_int_rden_o", issue_int_rden_o, e_ir);
      check_value("issue_int_wren_o", issue_int_wren_o, e_iw);
      check_value("issue_fp_wren_o", issue_fp_wren_o, e_fw);
      check_value("issue_op1_o", issue_op1_o, e_opnd[0]);
      check_value("issue_op2_o", issue_op2_o, e_opnd[1]);
      check_value("issue_op3_o", issue_op3_o, e_opnd[2]);
    end
  endtask

  task automatic csr_access(input logic we, input csr_addr_t adr, input csr_data_t dat,
                            input logic exc, input fflags_t flags);
    csr_data_t e_data;
    int        waits;
    case (adr)
      CSR_FFLAGS: e_data = {27'h0, fflags_model};
      CSR_FRM:    e_data = {29'h0, frm_model};
      CSR_FCSR:   e_data = {24'h0, frm_model, fflags_model};
      default:    e_data = '0;
    endcase
    {wb_cyc_i, wb_stb_i, wb_we_i} = {2'b11, we};
    wb_adr_i = adr;
    wb_dat_i = dat;
    exc_valid_i  = exc;
    exc_fflags_i = flags;
    if (we && (adr == CSR_FFLAGS || adr == CSR_FCSR)) fflags_model = dat[4:0];
    if (we && adr == CSR_FRM) frm_model = dat[2:0];
    if (we && adr == CSR_FCSR) frm_model = dat[7:5];
    if (exc) fflags_model = flags;   // Exception report beats the bus.
    waits = 0;
    @(negedge clock);
    exc_valid_i = 1'b0;
    while (!wb_ack_o && waits < 4) begin
      waits++;
      @(negedge clock);
    end
    checks++;
    assert (wb_ack_o)
      else begin
        errors++;
        $display("No Wishbone ack for CSR access at address %h", adr);
      end
    if (wb_ack_o && !we) check_value("wb_dat_o", wb_dat_o, e_data);
    {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
    @(negedge clock);
    checks++;
    assert (!wb_ack_o)
      else begin
        errors++;
        $display("Wishbone ack stayed high for a second cycle at address %h", adr);
      end
  endtask

  task automatic csr_random();
    logic [31:0] r;
    csr_addr_t   adr;
    r = next_random();
    case (r[2:0])
      3'd0, 3'd1: adr = CSR_FFLAGS;
      3'd2, 3'd3: adr = CSR_FRM;
      3'd4, 3'd5: adr = CSR_FCSR;
      default:    adr = 12'h100 | {4'h0, r[31:24]};   // Unmapped.
    endcase
    csr_access(r[3], adr, next_random(), r[5:4] == 2'b00, r[10:6]);
  endtask

  initial begin
    seed = 32'hb4c6_f04e;
    for (int i = 0; i < NUM_FP_REGS; i++) regs_model[i] = '0;
    reset = 1'b0;
    instr_i = '0;
    instr_valid_i = 1'b0;
    {wb_wren_i, ex_wren_i, mem_wren_i} = 3'b000;
    {wb_waddr_i, ex_waddr_i, mem_waddr_i} = '0;
    {wb_wdata_i, ex_wdata_i, mem_wdata_i} = '0;
    exc_valid_i = 1'b0;
    exc_fflags_i = '0;
    {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
    wb_adr_i = '0;
    wb_dat_i = '0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    check_value("issue_valid_o", issue_valid_o, 1'b0);
    check_value("wb_ack_o", wb_ack_o, 1'b0);
    for (int round = 0; round < ROUNDS; round++) begin
      instr_valid_i = 1'b0;
      wb_wren_i = 1'b0;
      exc_valid_i = 1'b0;
      repeat (10) csr_random();
      repeat (100) issue_random_instr();
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- source/fpu_front.sv
`timescale 1ns/1ps

module fpu_front (
  input  logic               clock,
  input  logic               reset,
  input  fpu_pkg::instr_t    instr_i,
  input  logic               instr_valid_i,
  input  logic               wb_wren_i,
  input  fpu_pkg::reg_addr_t wb_waddr_i,
  input  fpu_pkg::fp_data_t  wb_wdata_i,
  input  logic               ex_wren_i,
  input  fpu_pkg::reg_addr_t ex_waddr_i,
  input  fpu_pkg::fp_data_t  ex_wdata_i,
  input  logic               mem_wren_i,
  input  fpu_pkg::reg_addr_t mem_waddr_i,
  input  fpu_pkg::fp_data_t  mem_wdata_i,
  input  logic               exc_valid_i,
  input  fpu_pkg::fflags_t   exc_fflags_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  fpu_pkg::csr_addr_t wb_adr_i,
  input  fpu_pkg::csr_data_t wb_dat_i,
  output fpu_pkg::csr_data_t wb_dat_o,
  output logic               wb_ack_o,
  output logic               issue_valid_o,
  output fpu_pkg::fp_op_e    issue_op_o,
  output logic               issue_illegal_o,
  output logic [31:0]        issue_imm_o,
  output fpu_pkg::fmt_t      issue_fmt_o,
  output fpu_pkg::rm_t       issue_rm_o,
  output fpu_pkg::reg_addr_t issue_rd_o,
  output logic               issue_int_rden_o,
  output logic               issue_int_wren_o,
  output logic               issue_fp_wren_o,
  output fpu_pkg::fp_data_t  issue_op1_o,
  output fpu_pkg::fp_data_t  issue_op2_o,
  output fpu_pkg::fp_data_t  issue_op3_o
);
  import fpu_pkg::*;

  rm_t                          frm;
  fp_op_e                       dec_op;
  logic                         dec_illegal;
  logic [31:0]                  dec_imm;
  fmt_t                         dec_fmt;
  rm_t                          dec_rm;
  logic [NUM_OPERANDS-1:0]      dec_rden;
  reg_addr_t [NUM_OPERANDS-1:0] dec_raddr;
  reg_addr_t                    dec_rd;
  logic                         dec_int_rden;
  logic                         dec_int_wren;
  logic                         dec_fp_wren;
  fp_data_t [NUM_OPERANDS-1:0]  rf_rdata;
  fp_data_t [NUM_OPERANDS-1:0]  operand;

  fp_decode decode_i (
    .instr_i(instr_i), .frm_i(frm), .op_o(dec_op), .illegal_o(dec_illegal),
    .imm_o(dec_imm), .fmt_o(dec_fmt), .rm_o(dec_rm), .rden_o(dec_rden),
    .raddr_o(dec_raddr), .rd_o(dec_rd), .int_rden_o(dec_int_rden),
    .int_wren_o(dec_int_wren), .fp_wren_o(dec_fp_wren)
  );

  fp_regfile regfile_i (
    .clock(clock), .wren_i(wb_wren_i), .waddr_i(wb_waddr_i), .wdata_i(wb_wdata_i),
    .raddr_i(dec_raddr), .rdata_o(rf_rdata)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One forwarding lane per source operand
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar k = 0; k < NUM_OPERANDS; k++) begin : g_lane
    fp_operand_fwd lane_i (
      .rden_i(dec_rden[k]), .raddr_i(dec_raddr[k]), .rdata_i(rf_rdata[k]),
      .ex_wren_i(ex_wren_i), .ex_waddr_i(ex_waddr_i), .ex_wdata_i(ex_wdata_i),
      .mem_wren_i(mem_wren_i), .mem_waddr_i(mem_waddr_i), .mem_wdata_i(mem_wdata_i),
      .operand_o(operand[k])
    );
  end

  fp_csr csr_i (
    .clock(clock), .reset(reset), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
    .exc_valid_i(exc_valid_i), .exc_fflags_i(exc_fflags_i),
    .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .frm_o(frm)
  );

  fp_issue_reg issue_i (
    .clock(clock), .reset(reset), .valid_i(instr_valid_i), .op_i(dec_op),
    .illegal_i(dec_illegal), .imm_i(dec_imm), .fmt_i(dec_fmt), .rm_i(dec_rm),
    .rd_i(dec_rd), .int_rden_i(dec_int_rden), .int_wren_i(dec_int_wren),
    .fp_wren_i(dec_fp_wren), .operand_i(operand),
    .issue_valid_o(issue_valid_o), .issue_op_o(issue_op_o),
    .issue_illegal_o(issue_illegal_o), .issue_imm_o(issue_imm_o),
    .issue_fmt_o(issue_fmt_o), .issue_rm_o(issue_rm_o), .issue_rd_o(issue_rd_o),
    .issue_int_rden_o(issue_int_rden_o), .issue_int_wren_o(issue_int_wren_o),
    .issue_fp_wren_o(issue_fp_wren_o), .issue_op1_o(issue_op1_o),
    .issue_op2_o(issue_op2_o), .issue_op3_o(issue_op3_o)
  );

endmodule

//--- source/fp_issue_reg.sv
`timescale 1ns/1ps

module fp_issue_reg (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          valid_i,
  input  fpu_pkg::fp_op_e                               op_i,
  input  logic                                          illegal_i,
  input  logic [31:0]                                   imm_i,
  input  fpu_pkg::fmt_t                                 fmt_i,
  input  fpu_pkg::rm_t                                  rm_i,
  input  fpu_pkg::reg_addr_t                            rd_i,
  input  logic                                          int_rden_i,
  input  logic                                          int_wren_i,
  input  logic                                          fp_wren_i,
  input  fpu_pkg::fp_data_t [fpu_pkg::NUM_OPERANDS-1:0] operand_i,
  output logic                                          issue_valid_o,
  output fpu_pkg::fp_op_e                               issue_op_o,
  output logic                                          issue_illegal_o,
  output logic [31:0]                                   issue_imm_o,
  output fpu_pkg::fmt_t                                 issue_fmt_o,
  output fpu_pkg::rm_t                                  issue_rm_o,
  output fpu_pkg::reg_addr_t                            issue_rd_o,
  output logic                                          issue_int_rden_o,
  output logic                                          issue_int_wren_o,
  output logic                                          issue_fp_wren_o,
  output fpu_pkg::fp_data_t                             issue_op1_o,
  output fpu_pkg::fp_data_t                             issue_op2_o,
  output fpu_pkg::fp_data_t                             issue_op3_o
);
  import fpu_pkg::*;

  always_ff @(posedge clock) begin
    if (!reset) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= valid_i;
    end
  end

  // Payload follows the decoder every cycle.
  always_ff @(posedge clock) begin
    issue_op_o       <= op_i;
    issue_illegal_o  <= illegal_i;
    issue_imm_o      <= imm_i;
    issue_fmt_o      <= fmt_i;
    issue_rm_o       <= rm_i;
    issue_rd_o       <= rd_i;
    issue_int_rden_o <= int_rden_i;
    issue_int_wren_o <= int_wren_i;
    issue_fp_wren_o  <= fp_wren_i;
    issue_op1_o      <= operand_i[0];
    issue_op2_o      <= operand_i[1];
    issue_op3_o      <= operand_i[2];
  end

  a_illegal_no_op: assert property (@(posedge clock) disable iff (!reset)
    valid_i && illegal_i |-> op_i == OP_NONE)
    else $error("illegal instruction issued with op %0d", op_i);

endmodule

//--- source/fp_csr.sv
`timescale 1ns/1ps

module fp_csr (
  input  logic                clock,
  input  logic                reset,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  fpu_pkg::csr_addr_t  wb_adr_i,
  input  fpu_pkg::csr_data_t  wb_dat_i,
  input  logic                exc_valid_i,
  input  fpu_pkg::fflags_t    exc_fflags_i,
  output fpu_pkg::csr_data_t  wb_dat_o,
  output logic                wb_ack_o,
  output fpu_pkg::rm_t        frm_o
);
  import fpu_pkg::*;

  fflags_t   fflags;
  rm_t       frm;
  logic      req;
  csr_data_t rd_data;

  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;   // One ack per request.

  always_comb begin
    case (wb_adr_i)
      CSR_FFLAGS: rd_data = {27'h0, fflags};
      CSR_FRM:    rd_data = {29'h0, frm};
      CSR_FCSR:   rd_data = {24'h0, frm, fflags};
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      fflags   <= '0;
      frm      <= '0;
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;
      if (req && wb_we_i) begin
        case (wb_adr_i)
          CSR_FFLAGS: fflags <= wb_dat_i[4:0];
          CSR_FRM:    frm <= wb_dat_i[2:0];
          CSR_FCSR: begin
            fflags <= wb_dat_i[4:0];
            frm    <= wb_dat_i[7:5];
          end
          default: ;
        endcase
      end
      if (exc_valid_i) begin
        fflags <= exc_fflags_i;   // Beats a bus write.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req) begin
      wb_dat_o <= rd_data;
    end
  end

  assign frm_o = frm;

  a_req_known: assert property (@(posedge clock) disable iff (!reset)
    wb_cyc_i && wb_stb_i |-> !$isunknown({wb_we_i, wb_adr_i}))
    else $error("wishbone request with unknown control or address");

endmodule

//--- source/fp_operand_fwd.sv
`timescale 1ns/1ps

module fp_operand_fwd (
  input  logic               rden_i,
  input  fpu_pkg::reg_addr_t raddr_i,
  input  fpu_pkg::fp_data_t  rdata_i,
  input  logic               ex_wren_i,
  input  fpu_pkg::reg_addr_t ex_waddr_i,
  input  fpu_pkg::fp_data_t  ex_wdata_i,
  input  logic               mem_wren_i,
  input  fpu_pkg::reg_addr_t mem_waddr_i,
  input  fpu_pkg::fp_data_t  mem_wdata_i,
  output fpu_pkg::fp_data_t  operand_o
);

  // Newest producer wins.
  always_comb begin
    operand_o = '0;
    if (rden_i) begin
      if (ex_wren_i && ex_waddr_i == raddr_i) begin
        operand_o = ex_wdata_i;
      end else if (mem_wren_i && mem_waddr_i == raddr_i) begin
        operand_o = mem_wdata_i;
      end else begin
        operand_o = rdata_i;
      end
    end
  end

endmodule

//--- source/fp_regfile.sv
`timescale 1ns/1ps

module fp_regfile (
  input  logic                                           clock,
  input  logic                                           wren_i,
  input  fpu_pkg::reg_addr_t                             waddr_i,
  input  fpu_pkg::fp_data_t                              wdata_i,
  input  fpu_pkg::reg_addr_t [fpu_pkg::NUM_OPERANDS-1:0] raddr_i,
  output fpu_pkg::fp_data_t  [fpu_pkg::NUM_OPERANDS-1:0] rdata_o
);
  import fpu_pkg::*;

  fp_data_t regs [NUM_FP_REGS] = '{default: '0};

  always_ff @(posedge clock) begin
    if (wren_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Reads see the value before a write on the same edge.
  always_comb begin
    for (int k = 0; k < NUM_OPERANDS; k++) begin
      rdata_o[k] = regs[raddr_i[k]];
    end
  end

  a_waddr_known: assert property (@(posedge clock) wren_i |-> !$isunknown(waddr_i))
    else $error("register write with unknown address");

endmodule

//--- source/fp_decode.sv
`timescale 1ns/1ps

module fp_decode (
  input  fpu_pkg::instr_t                                instr_i,
  input  fpu_pkg::rm_t                                   frm_i,
  output fpu_pkg::fp_op_e                                op_o,
  output logic                                           illegal_o,
  output logic [31:0]                                    imm_o,
  output fpu_pkg::fmt_t                                  fmt_o,
  output fpu_pkg::rm_t                                   rm_o,
  output logic [fpu_pkg::NUM_OPERANDS-1:0]               rden_o,
  output fpu_pkg::reg_addr_t [fpu_pkg::NUM_OPERANDS-1:0] raddr_o,
  output fpu_pkg::reg_addr_t                             rd_o,
  output logic                                           int_rden_o,
  output logic                                           int_wren_o,
  output logic                                           fp_wren_o
);
  import fpu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] funct5;
  rm_t        rm_field;
  fp_op_e     op;
  logic       uses_rm;
  logic       rm_reserved;

  assign opcode   = instr_i[6:0];
  assign funct3   = instr_i[14:12];
  assign funct5   = instr_i[31:27];
  assign rm_field = instr_i[14:12];

  always_comb begin
    op = OP_NONE;
    case (opcode)
      OPCODE_FLOAD:
        case (funct3)
          FUNCT_W: op = OP_FLW;
          FUNCT_D: op = OP_FLD;
          default: op = OP_NONE;
        endcase
      OPCODE_FSTORE:
        case (funct3)
          FUNCT_W: op = OP_FSW;
          FUNCT_D: op = OP_FSD;
          default: op = OP_NONE;
        endcase
      OPCODE_FP:
        case (funct5)
          FUNCT_FADD:     op = OP_FADD;
          FUNCT_FSUB:     op = OP_FSUB;
          FUNCT_FMUL:     op = OP_FMUL;
          FUNCT_FDIV:     op = OP_FDIV;
          FUNCT_FSQRT:    op = OP_FSQRT;
          FUNCT_FSGNJ:    op = OP_FSGNJ;
          FUNCT_FMINMAX:  op = OP_FMINMAX;
          FUNCT_FCMP:     op = OP_FCMP;
          FUNCT_FMV_F2I:  op = (funct3 == 3'd0) ? OP_FMV_F2I :
                               (funct3 == 3'd1) ? OP_FCLASS : OP_NONE;
          FUNCT_FMV_I2F:  op = OP_FMV_I2F;
          FUNCT_FCVT_F2F: op = OP_FCVT_F2F;
          FUNCT_FCVT_F2I: op = OP_FCVT_F2I;
          FUNCT_FCVT_I2F: op = OP_FCVT_I2F;
          default:        op = OP_NONE;
        endcase
      OPCODE_FMADD:  op = OP_FMADD;
      OPCODE_FMSUB:  op = OP_FMSUB;
      OPCODE_FNMSUB: op = OP_FNMSUB;
      OPCODE_FNMADD: op = OP_FNMADD;
      default:       op = OP_NONE;
    endcase
  end

  // Enables follow the operation class.
  always_comb begin
    imm_o      = '0;
    rden_o     = '0;
    int_rden_o = 1'b0;
    int_wren_o = 1'b0;
    fp_wren_o  = 1'b0;
    case (op)
      OP_FLW, OP_FLD: begin
        imm_o      = {{20{instr_i[31]}}, instr_i[31:20]};
        int_rden_o = 1'b1;
        fp_wren_o  = 1'b1;
      end
      OP_FSW, OP_FSD: begin
        imm_o      = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
        int_rden_o = 1'b1;
        rden_o     = 3'b010;   // Store data comes from rs2.
      end
      OP_FADD, OP_FSUB, OP_FMUL, OP_FDIV, OP_FSGNJ, OP_FMINMAX: begin
        rden_o    = 3'b011;
        fp_wren_o = 1'b1;
      end
      OP_FSQRT, OP_FCVT_F2F: begin
        rden_o    = 3'b001;
        fp_wren_o = 1'b1;
      end
      OP_FCMP: begin
        rden_o     = 3'b011;
        int_wren_o = 1'b1;
      end
      OP_FMV_F2I, OP_FCLASS, OP_FCVT_F2I: begin
        rden_o     = 3'b001;
        int_wren_o = 1'b1;
      end
      OP_FMV_I2F, OP_FCVT_I2F: begin
        int_rden_o = 1'b1;
        fp_wren_o  = 1'b1;
      end
      OP_FMADD, OP_FMSUB, OP_FNMSUB, OP_FNMADD: begin
        rden_o    = 3'b111;
        fp_wren_o = 1'b1;
      end
      default: ;
    endcase
  end

  assign uses_rm = op inside {OP_FADD, OP_FSUB, OP_FMUL, OP_FDIV, OP_FSQRT,
                              OP_FCVT_F2F, OP_FCVT_F2I, OP_FCVT_I2F,
                              OP_FMADD, OP_FMSUB, OP_FNMSUB, OP_FNMADD};
  assign rm_reserved = uses_rm && (rm_field == 3'd5 || rm_field == 3'd6);

  assign illegal_o = (op == OP_NONE) || rm_reserved;
  assign op_o      = rm_reserved ? OP_NONE : op;
  assign rm_o      = (rm_field == RM_DYN) ? frm_i : rm_field;
  assign fmt_o     = instr_i[26:25];
  assign rd_o      = instr_i[11:7];

  assign raddr_o[0] = instr_i[19:15];
  assign raddr_o[1] = instr_i[24:20];
  assign raddr_o[2] = instr_i[31:27];

endmodule

//--- source/fpu_pkg.sv
package fpu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [31:0] instr_t;
  typedef logic [63:0] fp_data_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [4:0]  fflags_t;     // NV, DZ, OF, UF, NX.
  typedef logic [2:0]  rm_t;
  typedef logic [1:0]  fmt_t;

  typedef enum logic [4:0] {
    OP_NONE, OP_FLW, OP_FLD, OP_FSW, OP_FSD,
    OP_FADD, OP_FSUB, OP_FMUL, OP_FDIV, OP_FSQRT,
    OP_FSGNJ, OP_FMINMAX, OP_FCMP, OP_FMV_F2I, OP_FCLASS,
    OP_FMV_I2F, OP_FCVT_F2F, OP_FCVT_F2I, OP_FCVT_I2F,
    OP_FMADD, OP_FMSUB, OP_FNMSUB, OP_FNMADD
  } fp_op_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sizes and encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int NUM_FP_REGS  = 32;
  localparam int NUM_OPERANDS = 3;   // rs1, rs2, rs3.

  localparam logic [6:0] OPCODE_FLOAD  = 7'b0000111;
  localparam logic [6:0] OPCODE_FSTORE = 7'b0100111;
  localparam logic [6:0] OPCODE_FP     = 7'b1010011;
  localparam logic [6:0] OPCODE_FMADD  = 7'b1000011;
  localparam logic [6:0] OPCODE_FMSUB  = 7'b1000111;
  localparam logic [6:0] OPCODE_FNMSUB = 7'b1001011;
  localparam logic [6:0] OPCODE_FNMADD = 7'b1001111;

  // Funct5 field, instr[31:27].
  localparam logic [4:0] FUNCT_FADD     = 5'b00000;
  localparam logic [4:0] FUNCT_FSUB     = 5'b00001;
  localparam logic [4:0] FUNCT_FMUL     = 5'b00010;
  localparam logic [4:0] FUNCT_FDIV     = 5'b00011;
  localparam logic [4:0] FUNCT_FSQRT    = 5'b01011;
  localparam logic [4:0] FUNCT_FSGNJ    = 5'b00100;
  localparam logic [4:0] FUNCT_FMINMAX  = 5'b00101;
  localparam logic [4:0] FUNCT_FCMP     = 5'b10100;
  localparam logic [4:0] FUNCT_FMV_F2I  = 5'b11100;
  localparam logic [4:0] FUNCT_FMV_I2F  = 5'b11110;
  localparam logic [4:0] FUNCT_FCVT_F2F = 5'b01000;
  localparam logic [4:0] FUNCT_FCVT_F2I = 5'b11000;
  localparam logic [4:0] FUNCT_FCVT_I2F = 5'b11010;

  localparam logic [2:0] FUNCT_W = 3'd2;   // Word load/store width.
  localparam logic [2:0] FUNCT_D = 3'd3;   // Double load/store width.

  localparam csr_addr_t CSR_FFLAGS = 12'h001;
  localparam csr_addr_t CSR_FRM    = 12'h002;
  localparam csr_addr_t CSR_FCSR   = 12'h003;

  localparam rm_t RM_DYN = 3'd7;   // Take the mode from frm.

endpackage
